/* design/decode_collect.sv */
// In-order result collector
`include "decode_settings.svh"

module decode_collect
	import decode_pkg::*;
(
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic [`DECODE_LANES-1:0]              lane_valid,
	input  logic [`DECODE_LANES-1:0]              lane_ui,
	input  logic [`DECODE_LANES-1:0]              lane_rfwr,
	input  logic [`DECODE_LANES-1:0][`REG_W-1:0]  lane_rt,
	input  logic [`DECODE_LANES-1:0][`REG_W-1:0]  lane_rc,
	input  logic [`DECODE_LANES-1:0]              lane_need_rc,
	input  logic [`DECODE_LANES-1:0]              lane_branch,
	input  logic [`DECODE_LANES-1:0][`DATA_W-1:0] lane_imm,
	input  logic [`DECODE_LANES-1:0][`ADDR_W-1:0] lane_ip,
	input  logic                                  out_ack,
	output logic [`DECODE_LANES-1:0]              lane_take,
	output logic                                  out_req,
	output logic                                  out_ui,
	output logic                                  out_rfwr,
	output logic [`REG_W-1:0]                     out_rt,
	output logic [`REG_W-1:0]                     out_rc,
	output logic                                  out_need_rc,
	output logic                                  out_branch,
	output logic [`DATA_W-1:0]                    out_imm,
	output logic [`ADDR_W-1:0]                    out_ip
);
	localparam logic [`LANE_IDX_W-1:0] last_lane = `LANE_IDX_W'(`DECODE_LANES - 1);

	hs_state_e              state;
	logic [`LANE_IDX_W-1:0] rd_ptr;
	logic                   capture;

	// Lanes fill in round-robin order, so reading them the same way keeps order
	assign capture = (state == HS_IDLE) && lane_valid[rd_ptr];

	// ======================================
	// Output handshake and read pointer
	// ======================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= HS_IDLE;
			out_req <= 1'b0;
			lane_take <= '0;
			rd_ptr <= '0;
		end else begin
			lane_take <= '0;
			case (state)
				HS_IDLE: begin
					if (capture) begin
						out_req <= 1'b1;
						state <= HS_ACK;
					end
				end
				HS_ACK: begin
					if (out_ack) begin
						out_req <= 1'b0;
						state <= HS_WAIT_LOW;
					end
				end
				HS_WAIT_LOW: begin
					// Lane is only released once the consumer has finished
					if (!out_ack) begin
						lane_take <= `DECODE_LANES'(1) << rd_ptr;
						rd_ptr <= (rd_ptr == last_lane) ? '0 : rd_ptr + 1'b1;
						state <= HS_IDLE;
					end
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	// Output fields load on the same edge that raises out_req
	always_ff @(posedge clk) begin
		if (capture) begin
			out_ui <= lane_ui[rd_ptr];
			out_rfwr <= lane_rfwr[rd_ptr];
			out_rt <= lane_rt[rd_ptr];
			out_rc <= lane_rc[rd_ptr];
			out_need_rc <= lane_need_rc[rd_ptr];
			out_branch <= lane_branch[rd_ptr];
			out_imm <= lane_imm[rd_ptr];
			out_ip <= lane_ip[rd_ptr];
		end
	end

endmodule

/* design/decode_dispatch.sv */
// Round-robin instruction dispatcher
`include "decode_settings.svh"

module decode_dispatch
	import decode_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_req,
	input  logic [`INSTR_W-1:0]      in_ir,
	input  logic [`ADDR_W-1:0]       in_ip,
	input  logic [`DECODE_LANES-1:0] lane_valid,
	output logic                     in_ack,
	output logic [`DECODE_LANES-1:0] lane_load,
	output logic [`INSTR_W-1:0]      lane_ir,
	output logic [`ADDR_W-1:0]       lane_ip
);
	localparam logic [`LANE_IDX_W-1:0] last_lane = `LANE_IDX_W'(`DECODE_LANES - 1);

	hs_state_e               state;
	logic [`LANE_IDX_W-1:0]   wr_ptr;
	logic [`DECODE_LANES-1:0] pending;
	logic [`DECODE_LANES-1:0] valid_q;
	logic [`DECODE_LANES-1:0] busy;
	logic                     accept;

	// A lane is busy from its load until its valid flag has dropped again
	assign busy = pending | lane_valid;
	assign accept = (state == HS_IDLE) && in_req && !busy[wr_ptr];

	// ======================================
	// Input handshake and lane pointer
	// ======================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= HS_IDLE;
			in_ack <= 1'b0;
			lane_load <= '0;
			wr_ptr <= '0;
			pending <= '0;
			valid_q <= '0;
		end else begin
			lane_load <= '0;
			valid_q <= lane_valid;
			// Falling valid means the collector has drained that lane
			pending <= pending & ~(valid_q & ~lane_valid);
			case (state)
				HS_IDLE: begin
					if (accept) begin
						in_ack <= 1'b1;
						lane_load <= `DECODE_LANES'(1) << wr_ptr;
						pending[wr_ptr] <= 1'b1;
						wr_ptr <= (wr_ptr == last_lane) ? '0 : wr_ptr + 1'b1;
						state <= HS_ACK;
					end
				end
				HS_ACK: begin
					state <= HS_WAIT_LOW;
				end
				HS_WAIT_LOW: begin
					// The front end drops req once it has seen ack
					if (!in_req) begin
						in_ack <= 1'b0;
						state <= HS_IDLE;
					end
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	// Shared lane bus, sampled by the lane whose load bit pulses
	always_ff @(posedge clk) begin
		if (accept) begin
			lane_ir <= in_ir;
			lane_ip <= in_ip;
		end
	end

endmodule

/* design/decode_lane.sv */
// Single instruction decode lane
`include "decode_settings.svh"

module decode_lane
	import decode_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                load,
	input  logic [`INSTR_W-1:0] ir,
	input  logic [`ADDR_W-1:0]  ip,
	input  logic                take,
	output logic                valid,
	output logic                ui,
	output logic                rfwr,
	output logic [`REG_W-1:0]   rt,
	output logic [`REG_W-1:0]   rc,
	output logic                need_rc,
	output logic                branch,
	output logic [`DATA_W-1:0]  imm,
	output logic [`ADDR_W-1:0]  ip_out
);
	opcode_e             opcode;
	func_e               func;
	logic [`REG_W-1:0]   ir_rt;
	logic                d_ui;
	logic                d_rfwr;
	logic [`REG_W-1:0]   d_rt;
	logic [`REG_W-1:0]   d_rc;
	logic                d_need_rc;
	logic                d_branch;
	logic [`DATA_W-1:0]  d_imm;

	assign opcode = opcode_e'(ir[7:0]);
	assign func = func_e'(ir[31:26]);
	assign ir_rt = ir[13:8];

	// ======================================
	// Field decode
	// ======================================
	always_comb begin
		d_ui = 1'b1;
		d_rfwr = 1'b0;
		d_rt = '0;
		d_rc = '0;
		d_need_rc = 1'b0;
		d_imm = '0;
		// Conditional branches share opcode bits 7:3
		d_branch = (ir[7:3] == 5'b01001);
		case (opcode)
			BRK, NOP: d_ui = 1'b0;
			R1: begin
				if (func == ABS || func == NOT) begin
					d_ui = 1'b0;
					d_rfwr = 1'b1;
					d_rt = ir_rt;
				end
			end
			R2: begin
				case (func)
					ADD, SUB, AND, OR, XOR, SLT, SLTU, MUL: begin
						d_ui = 1'b0;
						d_rfwr = 1'b1;
						d_rt = ir_rt;
					end
					default: ;
				endcase
			end
			R3: begin
				case (func)
					SLL: begin
						d_ui = 1'b0;
						d_rfwr = 1'b1;
						d_rt = ir_rt;
					end
					// CHK reads the bound register from the Rt field
					CHK: begin
						d_ui = 1'b0;
						d_rc = ir_rt;
						d_need_rc = 1'b1;
					end
					default: ;
				endcase
			end
			ADDI, SUBFI, SEQI, SLTI: begin
				d_ui = 1'b0;
				d_rfwr = 1'b1;
				d_rt = ir_rt;
				d_imm = {{(`DATA_W - 12){ir[31]}}, ir[31:20]};
			end
			ORI, XORI, SLTUI: begin
				d_ui = 1'b0;
				d_rfwr = 1'b1;
				d_rt = ir_rt;
				d_imm = {{(`DATA_W - 12){1'b0}}, ir[31:20]};
			end
			// Ones above the field so the AND keeps the upper source bits
			ANDI: begin
				d_ui = 1'b0;
				d_rfwr = 1'b1;
				d_rt = ir_rt;
				d_imm = {{(`DATA_W - 12){1'b1}}, ir[31:20]};
			end
			BEQ, BNE, BLT, BGE: begin
				d_ui = 1'b0;
				d_imm = {{(`DATA_W - 14){ir[31]}}, ir[31:26], ir[13:8], 2'b00};
			end
			// Link register is one of four, picked by bits 9:8
			JAL: begin
				d_ui = 1'b0;
				d_rfwr = 1'b1;
				d_rt = {{(`REG_W - 2){1'b0}}, ir[9:8]};
				d_imm = {{(`DATA_W - 24){ir[31]}}, ir[31:10], 2'b00};
			end
			JALR: begin
				d_ui = 1'b0;
				d_rfwr = 1'b1;
				d_rt = {{(`REG_W - 2){1'b0}}, ir[9:8]};
				d_imm = {{(`DATA_W - 14){ir[31]}}, ir[31:20], 2'b00};
			end
			LDX: begin
				d_ui = 1'b0;
				d_rfwr = 1'b1;
				d_rt = ir_rt;
				d_imm = {{(`DATA_W - 8){ir[27]}}, ir[27:20]};
			end
			STX: begin
				d_ui = 1'b0;
				d_rc = ir_rt;
				d_need_rc = 1'b1;
				d_imm = {{(`DATA_W - 8){ir[27]}}, ir[27:20]};
			end
			default: ;
		endcase
	end

	// Valid rises the cycle after load and falls the cycle after take
	always_ff @(posedge clk) begin
		if (!rst_n)
			valid <= 1'b0;
		else if (load)
			valid <= 1'b1;
		else if (take)
			valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load) begin
			ui <= d_ui;
			rfwr <= d_rfwr;
			rt <= d_rt;
			rc <= d_rc;
			need_rc <= d_need_rc;
			branch <= d_branch;
			imm <= d_imm;
			ip_out <= ip;
		end
	end

endmodule

/* design/decode_pkg.sv */
// Decoder types
package decode_pkg;

	// ======================================
	// Opcodes in instruction bits 7:0
	// ======================================
	typedef enum logic [7:0] {
		BRK   = 8'h00,
		R1    = 8'h01,
		R2    = 8'h02,
		R3    = 8'h03,
		ADDI  = 8'h04,
		SUBFI = 8'h05,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		XORI  = 8'h0A,
		SEQI  = 8'h0C,
		SLTI  = 8'h0D,
		SLTUI = 8'h0E,
		LDX   = 8'h10,
		STX   = 8'h14,
		NOP   = 8'h3F,
		JAL   = 8'h40,
		JALR  = 8'h41,
		BEQ   = 8'h48,
		BNE   = 8'h49,
		BLT   = 8'h4A,
		BGE   = 8'h4B
	} opcode_e;

	// ======================================
	// Function codes in bits 31:26
	// ======================================
	// R1 uses the 0x0x range, R2 the 0x04 to 0x10 range, R3 the 0x2x range
	typedef enum logic [5:0] {
		ABS  = 6'h00,
		NOT  = 6'h01,
		ADD  = 6'h04,
		SUB  = 6'h05,
		AND  = 6'h08,
		OR   = 6'h09,
		XOR  = 6'h0A,
		SLT  = 6'h0C,
		SLTU = 6'h0D,
		MUL  = 6'h10,
		SLL  = 6'h20,
		CHK  = 6'h28
	} func_e;

	// Four-phase handshake progress
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACK,
		HS_WAIT_LOW
	} hs_state_e;

endpackage

/* design/decode_settings.svh */
// Decoder width settings
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Number of decode lanes, two or more
`define DECODE_LANES 3

// Lane pointer width, wide enough to index every lane
`define LANE_IDX_W 2

// Instruction word and fetch address
`define INSTR_W 32
`define ADDR_W 32

// Immediate and register number widths
`define DATA_W 64
`define REG_W 6

`endif

/* design/decode_top.sv */
// Multi-lane decoder top level
`include "decode_settings.svh"

module decode_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_req,
	input  logic [`INSTR_W-1:0] in_ir,
	input  logic [`ADDR_W-1:0]  in_ip,
	input  logic                out_ack,
	output logic                in_ack,
	output logic                out_req,
	output logic                out_ui,
	output logic                out_rfwr,
	output logic [`REG_W-1:0]   out_rt,
	output logic [`REG_W-1:0]   out_rc,
	output logic                out_need_rc,
	output logic                out_branch,
	output logic [`DATA_W-1:0]  out_imm,
	output logic [`ADDR_W-1:0]  out_ip
);
	// Shared bus from the dispatcher to every lane
	logic [`INSTR_W-1:0] lane_ir;
	logic [`ADDR_W-1:0]  lane_ip_in;

	// Per-lane control and results
	logic [`DECODE_LANES-1:0]              lane_load;
	logic [`DECODE_LANES-1:0]              lane_take;
	logic [`DECODE_LANES-1:0]              lane_valid;
	logic [`DECODE_LANES-1:0]              lane_ui;
	logic [`DECODE_LANES-1:0]              lane_rfwr;
	logic [`DECODE_LANES-1:0][`REG_W-1:0]  lane_rt;
	logic [`DECODE_LANES-1:0][`REG_W-1:0]  lane_rc;
	logic [`DECODE_LANES-1:0]              lane_need_rc;
	logic [`DECODE_LANES-1:0]              lane_branch;
	logic [`DECODE_LANES-1:0][`DATA_W-1:0] lane_imm;
	logic [`DECODE_LANES-1:0][`ADDR_W-1:0] lane_ip;

	decode_dispatch u_dispatch (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_req     (in_req),
		.in_ir      (in_ir),
		.in_ip      (in_ip),
		.lane_valid (lane_valid),
		.in_ack     (in_ack),
		.lane_load  (lane_load),
		.lane_ir    (lane_ir),
		.lane_ip    (lane_ip_in)
	);

	for (genvar i = 0; i < `DECODE_LANES; i++) begin : gen_lane
		decode_lane u_lane (
			.clk     (clk),
			.rst_n   (rst_n),
			.load    (lane_load[i]),
			.ir      (lane_ir),
			.ip      (lane_ip_in),
			.take    (lane_take[i]),
			.valid   (lane_valid[i]),
			.ui      (lane_ui[i]),
			.rfwr    (lane_rfwr[i]),
			.rt      (lane_rt[i]),
			.rc      (lane_rc[i]),
			.need_rc (lane_need_rc[i]),
			.branch  (lane_branch[i]),
			.imm     (lane_imm[i]),
			.ip_out  (lane_ip[i])
		);
	end

	decode_collect u_collect (
		.clk          (clk),
		.rst_n        (rst_n),
		.lane_valid   (lane_valid),
		.lane_ui      (lane_ui),
		.lane_rfwr    (lane_rfwr),
		.lane_rt      (lane_rt),
		.lane_rc      (lane_rc),
		.lane_need_rc (lane_need_rc),
		.lane_branch  (lane_branch),
		.lane_imm     (lane_imm),
		.lane_ip      (lane_ip),
		.out_ack      (out_ack),
		.lane_take    (lane_take),
		.out_req      (out_req),
		.out_ui       (out_ui),
		.out_rfwr     (out_rfwr),
		.out_rt       (out_rt),
		.out_rc       (out_rc),
		.out_need_rc  (out_need_rc),
		.out_branch   (out_branch),
		.out_imm      (out_imm),
		.out_ip       (out_ip)
	);

endmodule

/* filelist.f */
+incdir+design
design/decode_pkg.sv
design/decode_dispatch.sv
design/decode_lane.sv
design/decode_collect.sv
design/decode_top.sv
test/tb_clock.sv
test/decode_tb.sv

/* test/decode_tb.sv */
// Multi-lane decoder testbench
`include "decode_settings.svh"

module decode_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeout_cycles = 200;

	// Every valid opcode, then every listed function (R1 0..1, R2 2..9, R3 10..11)
	localparam logic [7:0] op_list [21] = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05,
		8'h08, 8'h09, 8'h0A, 8'h0C, 8'h0D, 8'h0E, 8'h10, 8'h14, 8'h3F, 8'h40, 8'h41,
		8'h48, 8'h49, 8'h4A, 8'h4B};
	localparam logic [5:0] func_list [12] = '{6'h00, 6'h01, 6'h04, 6'h05, 6'h08, 6'h09,
		6'h0A, 6'h0C, 6'h0D, 6'h10, 6'h20, 6'h28};

	typedef struct packed {
		logic                ui;
		logic                rfwr;
		logic [`REG_W-1:0]   rt;
		logic [`REG_W-1:0]   rc;
		logic                need_rc;
		logic                branch;
		logic [`DATA_W-1:0]  imm;
		logic [`ADDR_W-1:0]  ip;
	} fields_t;

	logic                clk;
	logic                rst_n;
	logic                in_req;
	logic [`INSTR_W-1:0] in_ir;
	logic [`ADDR_W-1:0]  in_ip;
	logic                out_ack;
	logic                in_ack;
	logic                out_req;
	logic                out_ui;
	logic                out_rfwr;
	logic [`REG_W-1:0]   out_rt;
	logic [`REG_W-1:0]   out_rc;
	logic                out_need_rc;
	logic                out_branch;
	logic [`DATA_W-1:0]  out_imm;
	logic [`ADDR_W-1:0]  out_ip;

	// Outstanding instructions in the order they were sent
	fields_t            exp_q[$];
	string              name_q[$];
	int                 delay_q[$];
	logic [`ADDR_W-1:0] next_ip;

	tb_clock clock_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	decode_top dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_req      (in_req),
		.in_ir       (in_ir),
		.in_ip       (in_ip),
		.out_ack     (out_ack),
		.in_ack      (in_ack),
		.out_req     (out_req),
		.out_ui      (out_ui),
		.out_rfwr    (out_rfwr),
		.out_rt      (out_rt),
		.out_rc      (out_rc),
		.out_need_rc (out_need_rc),
		.out_branch  (out_branch),
		.out_imm     (out_imm),
		.out_ip      (out_ip)
	);

	task automatic abort_run(input string reason);
		$display("TB FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic value_error(input string test, input string field,
			input logic [63:0] expected, input logic [63:0] actual);
		$display("FAIL %s: %s expected %0h actual %0h", test, field, expected, actual);
		abort_run({"Wrong value on ", field});
	endtask

	// All driving and sampling happens 2 ns after the rising edge
	task automatic next_cycle;
		@(posedge clk);
		#2;
	endtask

	task automatic wait_in_ack(input logic level);
		int n;
		n = 0;
		while (in_ack !== level) begin
			next_cycle();
			n++;
			if (n >= timeout_cycles)
				abort_run($sformatf("in_ack did not reach %0b in time", level));
		end
	endtask

	// ========================================
	// Expected fields from the decode rules
	// ========================================
	function automatic fields_t reference_fields(input logic [`INSTR_W-1:0] ir,
			input logic [`ADDR_W-1:0] ip);
		fields_t    f;
		logic [5:0] fn;
		logic       writes;
		logic       reads_rc;
		fn = ir[31:26];
		writes = 1'b0;
		reads_rc = 1'b0;
		f = '0;
		f.ui = 1'b1;
		f.branch = (ir[7:3] == 5'b01001);
		f.ip = ip;
		case (ir[7:0])
			8'h00, 8'h3F: f.ui = 1'b0;
			8'h01: writes = (fn == 6'h00 || fn == 6'h01);
			8'h02: begin
				case (fn)
					6'h04, 6'h05, 6'h08, 6'h09, 6'h0A, 6'h0C, 6'h0D, 6'h10: writes = 1'b1;
					default: ;
				endcase
			end
			8'h03: begin
				writes = (fn == 6'h20);
				reads_rc = (fn == 6'h28);
			end
			8'h04, 8'h05, 8'h0C, 8'h0D: begin
				writes = 1'b1;
				f.imm = `DATA_W'($signed(ir[31:20]));
			end
			8'h09, 8'h0A, 8'h0E: begin
				writes = 1'b1;
				f.imm = `DATA_W'(ir[31:20]);
			end
			8'h08: begin
				writes = 1'b1;
				f.imm = ~`DATA_W'(12'hFFF) | `DATA_W'(ir[31:20]);
			end
			8'h48, 8'h49, 8'h4A, 8'h4B: begin
				f.ui = 1'b0;
				f.imm = `DATA_W'($signed({ir[31:26], ir[13:8], 2'b00}));
			end
			8'h40: begin
				writes = 1'b1;
				f.imm = `DATA_W'($signed({ir[31:10], 2'b00}));
			end
			8'h41: begin
				writes = 1'b1;
				f.imm = `DATA_W'($signed({ir[31:20], 2'b00}));
			end
			8'h10: begin
				writes = 1'b1;
				f.imm = `DATA_W'($signed(ir[27:20]));
			end
			8'h14: begin
				reads_rc = 1'b1;
				f.imm = `DATA_W'($signed(ir[27:20]));
			end
			default: ;
		endcase
		if (writes) begin
			f.ui = 1'b0;
			f.rfwr = 1'b1;
			f.rt = ir[13:8];
		end
		if (reads_rc) begin
			f.ui = 1'b0;
			f.rc = ir[13:8];
			f.need_rc = 1'b1;
		end
		// JAL and JALR link to one of four registers
		if (ir[7:1] == 7'h20)
			f.rt = `REG_W'(ir[9:8]);
		return f;
	endfunction

	function automatic logic [`INSTR_W-1:0] with_opcode(input logic [7:0] op);
		logic [`INSTR_W-1:0] ir;
		ir = $urandom();
		ir[7:0] = op;
		return ir;
	endfunction

	function automatic logic [`INSTR_W-1:0] with_func(input logic [7:0] op, input logic [5:0] fn);
		logic [`INSTR_W-1:0] ir;
		ir = with_opcode(op);
		ir[31:26] = fn;
		return ir;
	endfunction

	// Front end side of the input handshake
	task automatic send(input string name, input logic [`INSTR_W-1:0] ir);
		name_q.push_back(name);
		exp_q.push_back(reference_fields(ir, next_ip));
		delay_q.push_back($urandom_range(6, 0));
		in_ir = ir;
		in_ip = next_ip;
		in_req = 1'b1;
		wait_in_ack(1'b1);
		in_req = 1'b0;
		wait_in_ack(1'b0);
		next_ip += 4;
	endtask

	// ========================================
	// Consumer side and result checks
	// ========================================
	task automatic check_result;
		fields_t e;
		string   t;
		int      delay;
		int      n;
		if (exp_q.size() == 0)
			abort_run("out_req rose with no instruction outstanding");
		e = exp_q[0];
		t = name_q[0];
		delay = delay_q[0];
		assert (out_ui === e.ui) else value_error(t, "ui", e.ui, out_ui);
		assert (out_rfwr === e.rfwr) else value_error(t, "rfwr", e.rfwr, out_rfwr);
		assert (out_rt === e.rt) else value_error(t, "rt", e.rt, out_rt);
		assert (out_rc === e.rc) else value_error(t, "rc", e.rc, out_rc);
		assert (out_need_rc === e.need_rc) else value_error(t, "need_rc", e.need_rc, out_need_rc);
		assert (out_branch === e.branch) else value_error(t, "branch", e.branch, out_branch);
		assert (out_imm === e.imm) else value_error(t, "imm", e.imm, out_imm);
		assert (out_ip === e.ip) else value_error(t, "ip", e.ip, out_ip);
		repeat (delay) next_cycle();
		out_ack = 1'b1;
		n = 0;
		while (out_req !== 1'b0) begin
			next_cycle();
			n++;
			if (n >= timeout_cycles)
				abort_run("out_req stayed high after out_ack");
		end
		out_ack = 1'b0;
		exp_q.delete(0);
		name_q.delete(0);
		delay_q.delete(0);
	endtask

	initial begin : consumer
		forever begin
			next_cycle();
			if (rst_n === 1'b1 && out_req === 1'b1)
				check_result();
		end
	end

	initial begin : stimulus
		int         n;
		logic [7:0] op;
		logic [5:0] fn;
		void'($urandom(32'h4a96ebc7));
		in_req = 1'b0;
		in_ir = '0;
		in_ip = '0;
		out_ack = 1'b0;
		next_ip = 32'h0000_1000;
		n = 0;
		while (rst_n !== 1'b1) begin
			next_cycle();
			n++;
			if (n >= timeout_cycles)
				abort_run("Reset was never released");
		end
		next_cycle();
		assert (in_ack === 1'b0) else value_error("reset", "in_ack", 1'b0, in_ack);
		assert (out_req === 1'b0) else value_error("reset", "out_req", 1'b0, out_req);

		// Each register group sees every function, so most are unlisted for it
		for (int g = 1; g <= 3; g++) begin
			for (int i = 0; i < 12; i++)
				send("register groups", with_func(8'(g), func_list[i]));
			send("register groups", with_func(8'(g), 6'h3F));
		end
		for (int i = 0; i < 2; i++) begin
			foreach (op_list[k]) begin
				if (op_list[k] >= 8'h04 && op_list[k] <= 8'h0E)
					send("immediate forms", with_opcode(op_list[k]));
				else if (op_list[k] >= 8'h40)
					send("control transfer", with_opcode(op_list[k]));
				else if (op_list[k] == 8'h10 || op_list[k] == 8'h14)
					send("memory", with_opcode(op_list[k]));
			end
		end
		send("special", with_opcode(8'h00));
		send("special", with_opcode(8'h3F));
		// 4C and 4F share the branch prefix without being branches
		send("unknown opcode", with_opcode(8'h06));
		send("unknown opcode", with_opcode(8'h4C));
		send("unknown opcode", with_opcode(8'h4F));
		send("unknown opcode", with_opcode(8'h80));
		send("unknown opcode", with_opcode(8'hFF));

		for (int i = 0; i < 20; i++) begin
			op = op_list[$urandom_range(20, 0)];
			case (op)
				8'h01: fn = func_list[$urandom_range(1, 0)];
				8'h02: fn = func_list[$urandom_range(9, 2)];
				8'h03: fn = func_list[$urandom_range(11, 10)];
				default: fn = 6'($urandom());
			endcase
			send("ordering burst", with_func(op, fn));
		end

		n = 0;
		while (exp_q.size() != 0) begin
			next_cycle();
			n++;
			if (n >= timeout_cycles)
				abort_run("Results still outstanding after the last instruction");
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

/* test/tb_clock.sv */
// Testbench clock and reset
module tb_clock (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset is held over five rising edges, then released just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule
